//--- rtl/cdc_consts.svh
`ifndef CDC_CONSTS_SVH
`define CDC_CONSTS_SVH

// ---------------------------------------------------------------------------
// Word crossing constants
// ---------------------------------------------------------------------------

// Width of one transferred word
`define CDC_DATA_W 16

// Flip-flops per level synchronizer
// Two is the minimum for a usable MTBF
`define CDC_SYNC_STAGES 2

`endif

//--- rtl/cdc_pkg.sv
`include "cdc_consts.svh"

package cdc_pkg;

    // -----------------------------------------------------------------------
    // Payload type
    // -----------------------------------------------------------------------

    // One word moved across the bridge
    typedef logic [`CDC_DATA_W-1:0] word_t;

    // -----------------------------------------------------------------------
    // Handshake state encodings
    // -----------------------------------------------------------------------

    // Source side of the four-phase cycle
    typedef enum logic [1:0] {
        SRC_IDLE  = 2'b00,  // Waiting for vld_in
        SRC_REQ   = 2'b01,  // Request up, waiting for ack to rise
        SRC_DRAIN = 2'b10   // Request down, waiting for ack to fall
    } src_state_e;

    // Destination side
    typedef enum logic {
        DST_IDLE = 1'b0,    // Waiting for synchronized request
        DST_ACK  = 1'b1     // Ack up until request falls
    } dst_state_e;

endpackage

//--- rtl/cdc_sync_bit.sv
`timescale 1ns/1ns

`include "cdc_consts.svh"

// Level synchronizer for a single bit
// Only point where a signal changes clock domain
module cdc_sync_bit (
    input  logic clk,
    input  logic rstn,
    input  logic d,
    output logic q
);

    // -----------------------------------------------------------------------
    // Flip-flop chain
    // -----------------------------------------------------------------------

    // Stage 0 is the metastable one
    logic [`CDC_SYNC_STAGES-1:0] sync_ff;

    // Shift toward the MSB, cleared low on reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_ff <= '0;
        end else begin
            sync_ff <= {sync_ff[`CDC_SYNC_STAGES-2:0], d};
        end
    end

    // Last stage is the settled level
    assign q = sync_ff[`CDC_SYNC_STAGES-1];

endmodule

//--- rtl/hs_src_ctrl.sv
`timescale 1ns/1ns

// Source side of the four-phase word handshake
// Accepts one word when idle and holds it while the request is up
module hs_src_ctrl (
    input  logic           src_clk,
    input  logic           src_rstn,
    input  logic           vld_in,
    input  cdc_pkg::word_t din,
    input  logic           ack_sync,
    output logic           src_req,
    output cdc_pkg::word_t hold_word,
    output logic           rdy_out
);

    // -----------------------------------------------------------------------
    // Handshake FSM
    // -----------------------------------------------------------------------

    cdc_pkg::src_state_e state;

    // Request and ready are flops
    // Request feeds a synchronizer so it must not glitch
    always_ff @(posedge src_clk or negedge src_rstn) begin
        if (!src_rstn) begin
            state   <= cdc_pkg::SRC_IDLE;
            src_req <= 1'b0;
            rdy_out <= 1'b0;
        end else begin
            // Ready is a single-cycle pulse
            rdy_out <= 1'b0;
            case (state)
                cdc_pkg::SRC_IDLE: begin
                    // Phase 1, raise request with the word load
                    if (vld_in) begin
                        src_req <= 1'b1;
                        state   <= cdc_pkg::SRC_REQ;
                    end
                end
                cdc_pkg::SRC_REQ: begin
                    // Phase 3, ack seen so drop request
                    if (ack_sync) begin
                        src_req <= 1'b0;
                        state   <= cdc_pkg::SRC_DRAIN;
                    end
                end
                cdc_pkg::SRC_DRAIN: begin
                    // Phase 4 observed, cycle closed
                    if (!ack_sync) begin
                        rdy_out <= 1'b1;
                        state   <= cdc_pkg::SRC_IDLE;
                    end
                end
                default: begin
                    // Unused encoding, recover to idle
                    src_req <= 1'b0;
                    state   <= cdc_pkg::SRC_IDLE;
                end
            endcase
        end
    end

    // -----------------------------------------------------------------------
    // Holding register
    // -----------------------------------------------------------------------

    // Loaded only in idle
    // Stays still for the whole request and drain phases
    // vld_in outside idle is dropped here too
    always_ff @(posedge src_clk) begin
        if (state == cdc_pkg::SRC_IDLE && vld_in) begin
            hold_word <= din;
        end
    end

endmodule

//--- rtl/hs_dst_capture.sv
`timescale 1ns/1ns

// Destination side of the four-phase word handshake
// One capture per rising request
// Ack follows the request level
module hs_dst_capture (
    input  logic           dst_clk,
    input  logic           dst_rstn,
    input  logic           req_sync,
    input  cdc_pkg::word_t hold_word,
    output logic           dst_ack,
    output logic           vld_out,
    output cdc_pkg::word_t dout
);

    // -----------------------------------------------------------------------
    // Capture FSM
    // -----------------------------------------------------------------------

    cdc_pkg::dst_state_e state;

    always_ff @(posedge dst_clk or negedge dst_rstn) begin
        if (!dst_rstn) begin
            state   <= cdc_pkg::DST_IDLE;
            dst_ack <= 1'b0;
            vld_out <= 1'b0;
            dout    <= '0;
        end else begin
            // Valid is a single-cycle pulse
            vld_out <= 1'b0;
            case (state)
                cdc_pkg::DST_IDLE: begin
                    // Request has passed the synchronizer
                    // hold_word has been stable since before it rose
                    if (req_sync) begin
                        dout    <= hold_word;
                        vld_out <= 1'b1;
                        dst_ack <= 1'b1;
                        state   <= cdc_pkg::DST_ACK;
                    end
                end
                cdc_pkg::DST_ACK: begin
                    // Hold ack until request drops
                    // A long request never causes a second capture
                    if (!req_sync) begin
                        dst_ack <= 1'b0;
                        state   <= cdc_pkg::DST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/cdc_word_bridge.sv
`timescale 1ns/1ns

// Word bridge from src_clk to dst_clk
// Request/ack levels are synchronized, the word itself is not
module cdc_word_bridge (
    // Source clock domain
    input  logic           src_clk,
    input  logic           src_rstn,
    input  logic           vld_in,
    input  cdc_pkg::word_t din,
    output logic           rdy_out,

    // Destination clock domain
    input  logic           dst_clk,
    input  logic           dst_rstn,
    output logic           vld_out,
    output cdc_pkg::word_t dout
);

    // -----------------------------------------------------------------------
    // Crossing signals
    // -----------------------------------------------------------------------

    logic           src_req;    // src_clk level
    logic           dst_ack;    // dst_clk level
    logic           req_sync;   // src_req seen in dst_clk
    logic           ack_sync;   // dst_ack seen in src_clk
    cdc_pkg::word_t hold_word;  // Stable while src_req is high

    // Source FSM and holding register
    hs_src_ctrl u_src (
        .src_clk   (src_clk),
        .src_rstn  (src_rstn),
        .vld_in    (vld_in),
        .din       (din),
        .ack_sync  (ack_sync),
        .src_req   (src_req),
        .hold_word (hold_word),
        .rdy_out   (rdy_out)
    );

    // Request into the destination domain
    cdc_sync_bit u_sync_req (
        .clk  (dst_clk),
        .rstn (dst_rstn),
        .d    (src_req),
        .q    (req_sync)
    );

    // Destination capture and ack
    hs_dst_capture u_dst (
        .dst_clk   (dst_clk),
        .dst_rstn  (dst_rstn),
        .req_sync  (req_sync),
        .hold_word (hold_word),
        .dst_ack   (dst_ack),
        .vld_out   (vld_out),
        .dout      (dout)
    );

    // Ack back into the source domain
    cdc_sync_bit u_sync_ack (
        .clk  (src_clk),
        .rstn (src_rstn),
        .d    (dst_ack),
        .q    (ack_sync)
    );

endmodule

//--- bench/cdc_word_bridge_assert.sv
`timescale 1ns/1ns

// Protocol checks on the word bridge, bound into cdc_word_bridge
module cdc_word_bridge_assert (
    input logic           src_clk,
    input logic           src_rstn,
    input logic           dst_clk,
    input logic           dst_rstn,
    input logic           vld_out,
    input logic           rdy_out,
    input cdc_pkg::word_t dout,
    input logic           src_req,
    input logic           ack_sync,
    input cdc_pkg::word_t hold_word
);

    // ------------------------------------------------------------------------
    // Destination domain
    // ------------------------------------------------------------------------

    // Single-cycle vld_out
    vld_out_pulse: assert property (@(posedge dst_clk) disable iff (!dst_rstn)
        vld_out |=> !vld_out)
    else begin
        $error("vld_out stayed high for two dst_clk cycles");
        tb_cdc_word_bridge.assert_dst_errors = tb_cdc_word_bridge.assert_dst_errors + 1;
    end

    // Cleared during reset and on the first edge after
    dst_reset_clear: assert property (@(posedge dst_clk)
        (!dst_rstn || $rose(dst_rstn)) |-> (!vld_out && dout == '0))
    else begin
        $error("vld_out or dout not cleared around destination reset");
        tb_cdc_word_bridge.assert_dst_errors = tb_cdc_word_bridge.assert_dst_errors + 1;
    end

    // ------------------------------------------------------------------------
    // Source domain
    // ------------------------------------------------------------------------

    // Single-cycle rdy_out
    rdy_out_pulse: assert property (@(posedge src_clk) disable iff (!src_rstn)
        rdy_out |=> !rdy_out)
    else begin
        $error("rdy_out stayed high for two src_clk cycles");
        tb_cdc_word_bridge.assert_src_errors = tb_cdc_word_bridge.assert_src_errors + 1;
    end

    src_reset_clear: assert property (@(posedge src_clk)
        (!src_rstn || $rose(src_rstn)) |-> !rdy_out)
    else begin
        $error("rdy_out not cleared around source reset");
        tb_cdc_word_bridge.assert_src_errors = tb_cdc_word_bridge.assert_src_errors + 1;
    end

    // Word frozen while the request stays up
    hold_stable: assert property (@(posedge src_clk) disable iff (!src_rstn)
        (src_req && $past(src_req)) |-> $stable(hold_word))
    else begin
        $error("hold_word changed while src_req was high");
        tb_cdc_word_bridge.assert_src_errors = tb_cdc_word_bridge.assert_src_errors + 1;
    end

    // Request only drops once the ack has been seen
    req_fall_after_ack: assert property (@(posedge src_clk) disable iff (!src_rstn)
        $fell(src_req) |-> $past(ack_sync))
    else begin
        $error("src_req fell before ack_sync had been high");
        tb_cdc_word_bridge.assert_src_errors = tb_cdc_word_bridge.assert_src_errors + 1;
    end

endmodule

//--- bench/tb_cdc_word_bridge.sv
`timescale 1ns/1ns

module tb_cdc_word_bridge;

    // ------------------------------------------------------------------------
    // Run length
    // ------------------------------------------------------------------------

    // Words sent one at a time through rdy_out
    localparam int NUM_WORDS      = 200;
    // Generous bound per word in dst_clk cycles
    localparam int TIMEOUT_CYCLES = NUM_WORDS * 40;

    // ------------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------------

    logic           src_clk = 1'b0;
    logic           src_rstn;
    logic           vld_in;
    cdc_pkg::word_t din;
    logic           rdy_out;
    logic           dst_clk = 1'b0;
    logic           dst_rstn;
    logic           vld_out;
    cdc_pkg::word_t dout;

    // Words accepted by the source, oldest first
    cdc_pkg::word_t expected_q[$];

    // Transfer counters
    int sent_count  = 0;
    int vld_count   = 0;
    int rdy_count   = 0;
    int cycle_count = 0;

    // One error counter per process
    int sb_errors         = 0;
    int src_errors        = 0;
    int end_errors        = 0;
    // Bumped by the bound assertion module
    int assert_dst_errors = 0;
    int assert_src_errors = 0;

    integer seed;

    // ------------------------------------------------------------------------
    // Clocks
    // ------------------------------------------------------------------------

    // 4 ns destination clock and 6 ns source clock
    always #2 dst_clk = ~dst_clk;
    always #3 src_clk = ~src_clk;

    // ------------------------------------------------------------------------
    // DUT and protocol checks
    // ------------------------------------------------------------------------

    cdc_word_bridge DUT (
        .src_clk  (src_clk),
        .src_rstn (src_rstn),
        .vld_in   (vld_in),
        .din      (din),
        .rdy_out  (rdy_out),
        .dst_clk  (dst_clk),
        .dst_rstn (dst_rstn),
        .vld_out  (vld_out),
        .dout     (dout)
    );

    // Internal handshake signals resolved inside the bridge
    bind cdc_word_bridge cdc_word_bridge_assert u_assert (
        .src_clk   (src_clk),
        .src_rstn  (src_rstn),
        .dst_clk   (dst_clk),
        .dst_rstn  (dst_rstn),
        .vld_out   (vld_out),
        .rdy_out   (rdy_out),
        .dout      (dout),
        .src_req   (src_req),
        .ack_sync  (ack_sync),
        .hold_word (hold_word)
    );

    // ------------------------------------------------------------------------
    // Destination side scoreboard
    // ------------------------------------------------------------------------

    // Outputs sampled on the edge after they were set
    always @(posedge dst_clk) begin : scoreboard
        cdc_pkg::word_t exp_word;
        if (dst_rstn && vld_out) begin
            vld_count++;
            if (expected_q.size() == 0) begin
                $display("ERROR at %0t: vld_out pulse with no accepted word pending", $time);
                sb_errors++;
            end else begin
                exp_word = expected_q.pop_front();
                assert (dout == exp_word) else begin
                    $display("MISMATCH time=%0t signal=dout expected=%h received=%h",
                             $time, exp_word, dout);
                    sb_errors++;
                end
            end
        end
    end

    // rdy_out must never run ahead of vld_out
    always @(posedge src_clk) begin : ready_monitor
        if (src_rstn && rdy_out) begin
            rdy_count++;
            assert (rdy_count <= vld_count) else begin
                $display("ERROR at %0t: rdy_out pulse %0d arrived before its vld_out",
                         $time, rdy_count);
                src_errors++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------------------

    always @(posedge dst_clk) begin : watchdog
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d dst_clk cycles, transfers did not complete (%0d of %0d)",
                     cycle_count, vld_count, NUM_WORDS);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin : stimulus
        cdc_pkg::word_t word;
        cdc_pkg::word_t busy_word;
        int             pick;
        int             total_errors;

        seed = 32'hf3771fe9;
        src_rstn <= 1'b0;
        dst_rstn <= 1'b0;
        vld_in   <= 1'b0;
        din      <= '0;

        // Each reset held 10 cycles of its own clock
        fork
            begin
                repeat (10) @(posedge src_clk);
                src_rstn <= 1'b1;
            end
            begin
                repeat (10) @(posedge dst_clk);
                dst_rstn <= 1'b1;
            end
        join

        // Outputs still cleared at release
        assert (!vld_out) else begin
            $display("MISMATCH time=%0t signal=vld_out expected=0 received=%b",
                     $time, vld_out);
            end_errors++;
        end
        assert (!rdy_out) else begin
            $display("MISMATCH time=%0t signal=rdy_out expected=0 received=%b",
                     $time, rdy_out);
            end_errors++;
        end
        assert (dout == '0) else begin
            $display("MISMATCH time=%0t signal=dout expected=0000 received=%h",
                     $time, dout);
            end_errors++;
        end

        for (int i = 0; i < NUM_WORDS; i++) begin
            // Strobe while idle so the word is accepted
            @(posedge src_clk);
            word = cdc_pkg::word_t'($random(seed));
            vld_in <= 1'b1;
            din    <= word;
            expected_q.push_back(word);
            sent_count++;
            @(posedge src_clk);
            vld_in <= 1'b0;

            // About one word in eight gets a strobe while busy
            // Handshake is still in SRC_REQ two cycles later
            pick = $random(seed);
            if ((pick & 7) == 0) begin
                busy_word = cdc_pkg::word_t'($random(seed));
                if (busy_word == word) begin
                    busy_word = ~word;
                end
                @(posedge src_clk);
                vld_in <= 1'b1;
                din    <= busy_word;
                @(posedge src_clk);
                vld_in <= 1'b0;
            end

            // Wait for the closing rdy_out
            @(posedge src_clk);
            while (!rdy_out) begin
                @(posedge src_clk);
            end
        end

        // Quiet period to catch any stray vld_out
        repeat (20) @(posedge dst_clk);

        // --------------------------------------------------------------------
        // End checks
        // --------------------------------------------------------------------

        assert (expected_q.size() == 0) else begin
            $display("ERROR at %0t: %0d accepted words never reached dout",
                     $time, expected_q.size());
            end_errors++;
        end
        assert (vld_count == sent_count) else begin
            $display("MISMATCH time=%0t signal=vld_out_count expected=%0d received=%0d",
                     $time, sent_count, vld_count);
            end_errors++;
        end
        assert (rdy_count == sent_count) else begin
            $display("MISMATCH time=%0t signal=rdy_out_count expected=%0d received=%0d",
                     $time, sent_count, rdy_count);
            end_errors++;
        end

        total_errors = sb_errors + src_errors + end_errors
                     + assert_dst_errors + assert_src_errors;
        $display("Error counts: scoreboard %0d, source %0d, end %0d, assertions %0d, total %0d",
                 sb_errors, src_errors, end_errors,
                 assert_dst_errors + assert_src_errors, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+rtl
rtl/cdc_pkg.sv
rtl/cdc_sync_bit.sv
rtl/hs_src_ctrl.sv
rtl/hs_dst_capture.sv
rtl/cdc_word_bridge.sv
bench/cdc_word_bridge_assert.sv
bench/tb_cdc_word_bridge.sv

//--- run.sh
#!/bin/sh
# Build and run the word bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    --top-module tb_cdc_word_bridge \
    -Mdir obj_dir \
    -f compile.f

# Assertion errors must not stop the run before the closing line
./obj_dir/Vtb_cdc_word_bridge +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    exit 0
else
    exit 1
fi
